// ==== sim.f ====
+incdir+.
tlb_pkg.sv
tlb_cp0_regs.sv
tlb_entry_array.sv
tlb_lookup.sv
tlb_xlat_port.sv
tlb_top.sv
tlb_props.sv
tb_tlb.sv

// ==== Makefile ====
# Verilator simulation of the TLB testbench

VERILATOR ?= verilator
TOP       ?= tb_tlb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_tlb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tlb_defines.svh"

module tb_tlb;
    import tlb_pkg::*;

    localparam int TIMEOUT = 100;

    logic        clk;
    logic        reset;
    apb_req_t    apb_req;
    apb_resp_t   apb_resp;
    xlat_req_t   xlat0_req;
    xlat_req_t   xlat1_req;
    xlat_resp_t  xlat0_resp;
    xlat_resp_t  xlat1_resp;

    integer      seed;
    int          checks;
    int          errors;
    int          test_errs;
    string       cur_test;
    logic        apb_err;
    logic [31:0] rd_val;

    tlb_top u_tlb_top (
        .clk        (clk),
        .reset      (reset),
        .apb_req    (apb_req),
        .apb_resp   (apb_resp),
        .xlat0_req  (xlat0_req),
        .xlat1_req  (xlat1_req),
        .xlat0_resp (xlat0_resp),
        .xlat1_resp (xlat1_resp)
    );

    always #2 clk = ~clk;

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errs++;
            $display("FAILED %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        $display("%s finished with %0d mismatches", cur_test, test_errs);
    endtask

    // Setup cycle, then access cycle held until pready
    task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!apb_resp.pready && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (!apb_resp.pready) begin
            $display("APB transfer to offset 0x%02h never completed", addr);
            $display("Errors found");
            $finish;
        end else begin
            apb_err = apb_resp.pslverr;
            rd_val  = apb_resp.prdata;
            @(posedge clk);
            apb_req.psel    <= 1'b0;
            apb_req.penable <= 1'b0;
            apb_req.pwrite  <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        apb_xfer(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [7:0] addr);
        apb_xfer(1'b0, addr, 32'd0);
    endtask

    function automatic logic [31:0] lo_word(logic [19:0] pfn, logic [2:0] c, logic d,
                                            logic v, logic g);
        return {6'd0, pfn, c, d, v, g};
    endfunction

    function automatic logic [31:0] hi_word(logic [18:0] vpn2, logic [7:0] asid);
        return {vpn2, 5'd0, asid};
    endfunction

    function automatic xlat_req_t make_req(logic mapped, logic write, logic [31:0] vaddr);
        return {mapped, write, vaddr};
    endfunction

    // refill, invalid, modified from high to low
    function automatic logic [31:0] resp_flags(xlat_resp_t resp);
        return {29'd0, resp.refill, resp.invalid, resp.modified};
    endfunction

    task automatic write_entry(input logic [4:0] idx, input logic [31:0] hi,
                               input logic [11:0] mask, input logic [31:0] lo0,
                               input logic [31:0] lo1);
        apb_write(`REG_INDEX, {27'd0, idx});
        apb_write(`REG_ENTRYHI, hi);
        apb_write(`REG_ENTRYLO0, lo0);
        apb_write(`REG_ENTRYLO1, lo1);
        apb_write(`REG_PAGEMASK, {7'd0, mask, 13'd0});
        apb_write(`REG_CMD, {30'd0, TLB_OP_WRITE});
    endtask

    task automatic probe_index(input logic [31:0] hi, input string what, input logic [31:0] exp);
        apb_write(`REG_ENTRYHI, hi);
        apb_write(`REG_CMD, {30'd0, TLB_OP_PROBE});
        apb_read(`REG_INDEX);
        check(what, exp, rd_val);
    endtask

    // Ports answer combinationally, sample mid-cycle
    task automatic drive_ports(input xlat_req_t r0, input xlat_req_t r1);
        @(posedge clk);
        xlat0_req <= r0;
        xlat1_req <= r1;
        @(negedge clk);
    endtask

    task automatic write_read_reg(input logic [7:0] addr, input string what,
                                  input logic [31:0] exp);
        apb_write(addr, 32'hFFFF_FFFF);
        apb_read(addr);
        check(what, exp, rd_val);
        check({what, " pslverr"}, 32'd0, {31'd0, apb_err});
    endtask

    task automatic reg_masking();
        start_test("reg_masking");
        write_read_reg(`REG_INDEX, "index", 32'h0000_001F);
        write_read_reg(`REG_ENTRYHI, "entryhi", 32'hFFFF_E0FF);
        write_read_reg(`REG_ENTRYLO0, "entrylo0", 32'h03FF_FFFF);
        write_read_reg(`REG_ENTRYLO1, "entrylo1", 32'h03FF_FFFF);
        write_read_reg(`REG_PAGEMASK, "pagemask", 32'h01FF_E000);
        apb_read(`REG_CMD);
        check("cmd", 32'd0, rd_val);
        apb_write(8'h18, 32'hFFFF_FFFF);
        check("range wr pslverr", 32'd1, {31'd0, apb_err});
        apb_read(8'h18);
        check("range rd pslverr", 32'd1, {31'd0, apb_err});
        check("range rd data", 32'd0, rd_val);
        apb_read(8'h06);
        check("misaligned pslverr", 32'd1, {31'd0, apb_err});
        check("misaligned rd data", 32'd0, rd_val);
        end_test();
    endtask

    task automatic write_then_read();
        logic [31:0] r;
        logic [4:0]  idx;
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic [1:0]  g;
        logic [11:0] mask;
        logic [31:0] lo0;
        logic [31:0] lo1;
        start_test("write_read");
        r    = $random(seed);
        idx  = r[4:0];
        asid = r[15:8];
        // One half global, the other not
        g    = {~r[16], r[16]};
        mask = r[29:18];
        r    = $random(seed);
        vpn2 = {3'b001, r[15:0]};
        r    = $random(seed);
        lo0  = lo_word(r[19:0], r[22:20], r[23], r[24], g[0]);
        r    = $random(seed);
        lo1  = lo_word(r[19:0], r[22:20], r[23], r[24], g[1]);
        write_entry(idx, hi_word(vpn2, asid), mask, lo0, lo1);
        apb_write(`REG_ENTRYHI, 32'd0);
        apb_write(`REG_ENTRYLO0, 32'd0);
        apb_write(`REG_ENTRYLO1, 32'd0);
        apb_write(`REG_PAGEMASK, 32'd0);
        apb_write(`REG_INDEX, {27'd0, idx});
        apb_write(`REG_CMD, {30'd0, TLB_OP_READ});
        apb_read(`REG_ENTRYHI);
        check("entryhi", hi_word(vpn2, asid), rd_val);
        apb_read(`REG_ENTRYLO0);
        check("entrylo0", {lo0[31:1], &g}, rd_val);
        apb_read(`REG_ENTRYLO1);
        check("entrylo1", {lo1[31:1], &g}, rd_val);
        apb_read(`REG_PAGEMASK);
        check("pagemask", {7'd0, mask, 13'd0}, rd_val);
        end_test();
    endtask

    task automatic probe_lookup();
        logic [31:0] r;
        logic [4:0]  idx;
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic [31:0] lo;
        start_test("probe");
        r    = $random(seed);
        idx  = r[4:0];
        asid = r[15:8];
        vpn2 = {3'b010, r[31:16]};
        r    = $random(seed);
        lo   = lo_word(r[19:0], 3'd0, 1'b1, 1'b1, 1'b0);
        write_entry(idx, hi_word(vpn2, asid), 12'd0, lo, lo);
        probe_index(hi_word(vpn2, asid), "hit", {27'd0, idx});
        probe_index(hi_word(vpn2 ^ 19'd1, asid), "miss vpn2", 32'h8000_0000);
        probe_index(hi_word(vpn2, asid ^ 8'h5a), "other asid", 32'h8000_0000);
        // Same entry made global
        write_entry(idx, hi_word(vpn2, asid), 12'd0, lo | 32'd1, lo | 32'd1);
        probe_index(hi_word(vpn2, asid ^ 8'h5a), "global", {27'd0, idx});
        end_test();
    endtask

    task automatic translate_pages();
        logic [31:0] r;
        logic [4:0]  idx;
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic [19:0] pfn0;
        logic [19:0] pfn1;
        logic [11:0] off;
        start_test("translate");
        r    = $random(seed);
        idx  = {1'b0, r[3:0]};
        asid = r[15:8];
        vpn2 = {3'b011, r[31:16]};
        r    = $random(seed);
        pfn0 = r[19:0];
        off  = r[31:20];
        r    = $random(seed);
        pfn1 = r[19:0];
        write_entry(idx, hi_word(vpn2, asid), 12'd0, lo_word(pfn0, 3'd0, 1'b1, 1'b1, 1'b0),
                    lo_word(pfn1, 3'd0, 1'b1, 1'b1, 1'b0));
        drive_ports(make_req(1'b1, 1'b0, {vpn2, 1'b0, off}),
                    make_req(1'b1, 1'b0, {vpn2, 1'b1, ~off}));
        check("even paddr", {pfn0, off}, xlat0_resp.paddr);
        check("odd paddr", {pfn1, ~off}, xlat1_resp.paddr);
        check("even flags", 32'd0, resp_flags(xlat0_resp));
        check("odd flags", 32'd0, resp_flags(xlat1_resp));
        // Lower index written first, upper one second
        vpn2 = vpn2 ^ 19'h100;
        write_entry(idx, hi_word(vpn2, asid), 12'd0, lo_word(pfn0, 3'd0, 1'b1, 1'b1, 1'b0),
                    lo_word(pfn0, 3'd0, 1'b1, 1'b1, 1'b0));
        write_entry({1'b1, idx[3:0]}, hi_word(vpn2, asid), 12'd0,
                    lo_word(~pfn0, 3'd0, 1'b1, 1'b1, 1'b0), lo_word(~pfn0, 3'd0, 1'b1, 1'b1, 1'b0));
        drive_ports(make_req(1'b1, 1'b0, {vpn2, 1'b0, off}),
                    make_req(1'b1, 1'b1, {vpn2, 1'b1, off}));
        check("priority port0", {pfn0, off}, xlat0_resp.paddr);
        check("priority port1", {pfn0, off}, xlat1_resp.paddr);
        end_test();
    endtask

    task automatic exception_flags();
        logic [31:0] r;
        logic [4:0]  idx;
        logic [18:0] vpn2;
        logic [18:0] miss;
        logic [7:0]  asid;
        logic [11:0] off;
        start_test("exceptions");
        r    = $random(seed);
        idx  = r[4:0];
        asid = r[15:8];
        vpn2 = {3'b100, r[31:16]};
        r    = $random(seed);
        miss = {3'b110, r[15:0]};
        off  = r[27:16];
        // Even half invalid, odd half valid and clean
        write_entry(idx, hi_word(vpn2, asid), 12'd0, lo_word(20'h12345, 3'd0, 1'b1, 1'b0, 1'b0),
                    lo_word(20'h54321, 3'd0, 1'b0, 1'b1, 1'b0));
        drive_ports(make_req(1'b1, 1'b0, {miss, 1'b0, off}),
                    make_req(1'b0, 1'b0, {miss, 1'b1, off}));
        check("refill flags", 32'h4, resp_flags(xlat0_resp));
        check("refill paddr", {20'd0, off}, xlat0_resp.paddr);
        check("unmapped flags", 32'd0, resp_flags(xlat1_resp));
        drive_ports(make_req(1'b1, 1'b0, {vpn2, 1'b0, off}),
                    make_req(1'b1, 1'b1, {vpn2, 1'b1, off}));
        check("invalid flags", 32'h2, resp_flags(xlat0_resp));
        check("modified flags", 32'h1, resp_flags(xlat1_resp));
        drive_ports(make_req(1'b1, 1'b0, {vpn2, 1'b1, off}),
                    make_req(1'b1, 1'b0, {vpn2, 1'b1, off}));
        check("clean read flags", 32'd0, resp_flags(xlat0_resp));
        end_test();
    endtask

    task automatic page_size_rule();
        logic [31:0] r;
        logic [4:0]  idx;
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic [31:0] lo;
        start_test("page_size");
        r    = $random(seed);
        idx  = r[4:0];
        asid = r[15:8];
        vpn2 = {3'b101, r[31:16]};
        r    = $random(seed);
        lo   = lo_word(r[19:0], 3'd0, 1'b1, 1'b1, 1'b0);
        write_entry(idx, hi_word(vpn2, asid), {r[30:20], 1'b1}, lo, lo);
        drive_ports(make_req(1'b1, 1'b0, {vpn2, 1'b0, 12'h0}),
                    make_req(1'b1, 1'b0, {vpn2, 1'b1, 12'h0}));
        check("even flags", 32'h4, resp_flags(xlat0_resp));
        check("odd flags", 32'h4, resp_flags(xlat1_resp));
        probe_index(hi_word(vpn2, asid), "probe", 32'h8000_0000);
        end_test();
    endtask

    initial begin
        seed      = 32'ha4e7_200b;
        clk       = 1'b0;
        reset     = 1'b1;
        apb_req   = '0;
        xlat0_req = '0;
        xlat1_req = '0;
        checks    = 0;
        errors    = 0;
        test_errs = 0;
        cur_test  = "reset";
        apb_err   = 1'b0;
        rd_val    = 32'd0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        reg_masking();
        write_then_read();
        probe_lookup();
        translate_pages();
        exception_flags();
        page_size_rule();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tlb_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_props (
    input logic                  clk,
    input logic                  reset,
    input tlb_pkg::apb_req_t     apb_req,
    input tlb_pkg::apb_resp_t    apb_resp,
    input tlb_pkg::xlat_resp_t   xlat0_resp,
    input tlb_pkg::xlat_resp_t   xlat1_resp
);
    import tlb_pkg::*;

    pslverr_in_access: assert property (@(posedge clk) disable iff (reset)
        apb_resp.pslverr |-> (apb_req.psel && apb_req.penable))
        else $error("pslverr outside an APB access cycle");

    // Refill and invalid exclude each other
    port0_refill_invalid: assert property (@(posedge clk) disable iff (reset)
        !(xlat0_resp.refill && xlat0_resp.invalid))
        else $error("port 0 refill and invalid together");

    port1_refill_invalid: assert property (@(posedge clk) disable iff (reset)
        !(xlat1_resp.refill && xlat1_resp.invalid))
        else $error("port 1 refill and invalid together");

    port0_modified_alone: assert property (@(posedge clk) disable iff (reset)
        xlat0_resp.modified |-> !(xlat0_resp.refill || xlat0_resp.invalid))
        else $error("port 0 modified with another exception");

    port1_modified_alone: assert property (@(posedge clk) disable iff (reset)
        xlat1_resp.modified |-> !(xlat1_resp.refill || xlat1_resp.invalid))
        else $error("port 1 modified with another exception");

endmodule

bind tlb_top tlb_props u_props (
    .clk        (clk),
    .reset      (reset),
    .apb_req    (apb_req),
    .apb_resp   (apb_resp),
    .xlat0_resp (xlat0_resp),
    .xlat1_resp (xlat1_resp)
);

`default_nettype wire

// ==== tlb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_top (
    input  logic                  clk,
    input  logic                  reset,
    input  tlb_pkg::apb_req_t     apb_req,
    output tlb_pkg::apb_resp_t    apb_resp,
    input  tlb_pkg::xlat_req_t    xlat0_req,
    input  tlb_pkg::xlat_req_t    xlat1_req,
    output tlb_pkg::xlat_resp_t   xlat0_resp,
    output tlb_pkg::xlat_resp_t   xlat1_resp
);
    import tlb_pkg::*;

    tlb_op_t                       op;
    logic [`TLB_IDX_W-1:0]         sel_index;
    tlb_entry_t                    wr_entry;
    tlb_entry_t                    rd_entry;
    tlb_entry_t [`TLB_ENTRIES-1:0] entries;
    logic [`VPN2_W-1:0]            cur_vpn2;
    logic [`ASID_W-1:0]            cur_asid;
    lookup_res_t                   probe_res;

    tlb_cp0_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_resp  (apb_resp),
        .rd_entry  (rd_entry),
        .probe_res (probe_res),
        .op        (op),
        .sel_index (sel_index),
        .wr_entry  (wr_entry),
        .cur_vpn2  (cur_vpn2),
        .cur_asid  (cur_asid)
    );

    tlb_entry_array u_array (
        .clk       (clk),
        .reset     (reset),
        .op        (op),
        .sel_index (sel_index),
        .wr_entry  (wr_entry),
        .rd_entry  (rd_entry),
        .entries   (entries)
    );

    // Probe needs only the hit index, so the page half is don't-care
    tlb_lookup u_probe (
        .entries (entries),
        .vpn2    (cur_vpn2),
        .odd     (1'b0),
        .asid    (cur_asid),
        .res     (probe_res)
    );

    tlb_xlat_port u_xlat0 (
        .entries (entries),
        .asid    (cur_asid),
        .req     (xlat0_req),
        .resp    (xlat0_resp)
    );

    tlb_xlat_port u_xlat1 (
        .entries (entries),
        .asid    (cur_asid),
        .req     (xlat1_req),
        .resp    (xlat1_resp)
    );

endmodule

`default_nettype wire

// ==== tlb_xlat_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_xlat_port (
    input  tlb_pkg::tlb_entry_t [`TLB_ENTRIES-1:0]  entries,
    input  logic [`ASID_W-1:0]                      asid,
    input  tlb_pkg::xlat_req_t                      req,
    output tlb_pkg::xlat_resp_t                     resp
);
    import tlb_pkg::*;

    lookup_res_t lk;

    tlb_lookup u_lookup (
        .entries (entries),
        .vpn2    (req.vaddr[31:13]),
        .odd     (req.vaddr[12]),
        .asid    (asid),
        .res     (lk)
    );

    // pfn is zero on a miss
    assign resp.paddr    = {lk.lo.pfn, req.vaddr[11:0]};
    assign resp.refill   = req.mapped & ~lk.hit;
    assign resp.invalid  = req.mapped & lk.hit & ~lk.lo.v;
    // Store to a clean valid page
    assign resp.modified = req.mapped & lk.hit & lk.lo.v & req.write & ~lk.lo.d;

endmodule

`default_nettype wire

// ==== tlb_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_lookup (
    input  tlb_pkg::tlb_entry_t [`TLB_ENTRIES-1:0]  entries,
    input  logic [`VPN2_W-1:0]                      vpn2,
    input  logic                                    odd,
    input  logic [`ASID_W-1:0]                      asid,
    output tlb_pkg::lookup_res_t                    res
);
    import tlb_pkg::*;

    logic [`TLB_ENTRIES-1:0] match;

    // Only 4 KiB pages, so any nonzero mask disqualifies
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = (entries[i].vpn2 == vpn2)
                    && (entries[i].g || (entries[i].asid == asid))
                    && (entries[i].mask == '0);
        end
    end

    // Scan from the top so the lowest hit is assigned last
    always_comb begin
        res = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                res.hit   = 1'b1;
                res.index = `TLB_IDX_W'(i);
                res.lo    = odd ? entries[i].lo1 : entries[i].lo0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tlb_entry_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_entry_array (
    input  logic                                    clk,
    input  logic                                    reset,
    input  tlb_pkg::tlb_op_t                        op,
    input  logic [`TLB_IDX_W-1:0]                   sel_index,
    input  tlb_pkg::tlb_entry_t                     wr_entry,
    output tlb_pkg::tlb_entry_t                     rd_entry,
    output tlb_pkg::tlb_entry_t [`TLB_ENTRIES-1:0]  entries
);
    import tlb_pkg::*;

    tlb_entry_t [`TLB_ENTRIES-1:0] entries_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            entries_q <= '0;
        end else if (op == TLB_OP_WRITE) begin
            entries_q[sel_index] <= wr_entry;
        end
    end

    assign rd_entry = entries_q[sel_index];
    // All entries feed the parallel lookups
    assign entries  = entries_q;

endmodule

`default_nettype wire

// ==== tlb_cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_cp0_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  tlb_pkg::apb_req_t      apb_req,
    output tlb_pkg::apb_resp_t     apb_resp,
    input  tlb_pkg::tlb_entry_t    rd_entry,
    input  tlb_pkg::lookup_res_t   probe_res,
    output tlb_pkg::tlb_op_t       op,
    output logic [`TLB_IDX_W-1:0]  sel_index,
    output tlb_pkg::tlb_entry_t    wr_entry,
    output logic [`VPN2_W-1:0]     cur_vpn2,
    output logic [`ASID_W-1:0]     cur_asid
);
    import tlb_pkg::*;

    logic                  index_p;
    logic [`TLB_IDX_W-1:0] index_idx;
    logic [`VPN2_W-1:0]    hi_vpn2;
    logic [`ASID_W-1:0]    hi_asid;
    tlb_lo_t               lo0_q;
    tlb_lo_t               lo1_q;
    logic                  lo0_g;
    logic                  lo1_g;
    logic [`MASK_W-1:0]    mask_q;
    tlb_op_t               op_q;

    logic                  access;
    logic                  addr_ok;
    logic                  wr_en;
    logic [31:0]           rd_data;

    assign access  = apb_req.psel & apb_req.penable;
    assign addr_ok = (apb_req.paddr <= `REG_CMD) && (apb_req.paddr[1:0] == 2'b00);
    assign wr_en   = access & apb_req.pwrite & addr_ok;

    // Unknown or misaligned offsets fall to zero
    always_comb begin
        case (apb_req.paddr)
            `REG_INDEX:    rd_data = {index_p, 26'd0, index_idx};
            `REG_ENTRYHI:  rd_data = {hi_vpn2, 5'd0, hi_asid};
            `REG_ENTRYLO0: rd_data = {6'd0, lo0_q, lo0_g};
            `REG_ENTRYLO1: rd_data = {6'd0, lo1_q, lo1_g};
            `REG_PAGEMASK: rd_data = {7'd0, mask_q, 13'd0};
            default:       rd_data = 32'd0;
        endcase
    end

    assign apb_resp.prdata  = apb_req.psel ? rd_data : 32'd0;
    assign apb_resp.pready  = 1'b1;
    assign apb_resp.pslverr = access & ~addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            index_p   <= 1'b0;
            index_idx <= '0;
            hi_vpn2   <= '0;
            hi_asid   <= '0;
            lo0_q     <= '0;
            lo1_q     <= '0;
            lo0_g     <= 1'b0;
            lo1_g     <= 1'b0;
            mask_q    <= '0;
            op_q      <= TLB_OP_NONE;
        end else begin
            op_q <= TLB_OP_NONE;
            if (wr_en) begin
                case (apb_req.paddr)
                    `REG_INDEX: begin
                        index_p   <= 1'b0;
                        index_idx <= apb_req.pwdata[4:0];
                    end
                    `REG_ENTRYHI: begin
                        hi_vpn2 <= apb_req.pwdata[31:13];
                        hi_asid <= apb_req.pwdata[7:0];
                    end
                    `REG_ENTRYLO0: begin
                        lo0_q <= apb_req.pwdata[25:1];
                        lo0_g <= apb_req.pwdata[0];
                    end
                    `REG_ENTRYLO1: begin
                        lo1_q <= apb_req.pwdata[25:1];
                        lo1_g <= apb_req.pwdata[0];
                    end
                    `REG_PAGEMASK: mask_q <= apb_req.pwdata[24:13];
                    `REG_CMD: begin
                        // Opcode zero issues nothing
                        if (apb_req.pwdata[1:0] != 2'b00) begin
                            op_q <= tlb_op_t'(apb_req.pwdata[1:0]);
                        end
                    end
                    default: ;
                endcase
            end

            // Command effects, one cycle after issue
            if (op_q == TLB_OP_READ) begin
                hi_vpn2 <= rd_entry.vpn2;
                hi_asid <= rd_entry.asid;
                lo0_q   <= rd_entry.lo0;
                lo1_q   <= rd_entry.lo1;
                lo0_g   <= rd_entry.g;
                lo1_g   <= rd_entry.g;
                mask_q  <= rd_entry.mask;
            end else if (op_q == TLB_OP_PROBE) begin
                index_p   <= ~probe_res.hit;
                index_idx <= probe_res.hit ? probe_res.index : '0;
            end
        end
    end

    assign op        = op_q;
    assign sel_index = index_idx;
    assign cur_vpn2  = hi_vpn2;
    assign cur_asid  = hi_asid;

    // Entry is global only when both halves say so
    assign wr_entry.vpn2 = hi_vpn2;
    assign wr_entry.asid = hi_asid;
    assign wr_entry.mask = mask_q;
    assign wr_entry.g    = lo0_g & lo1_g;
    assign wr_entry.lo0  = lo0_q;
    assign wr_entry.lo1  = lo1_q;

endmodule

`default_nettype wire

// ==== tlb_pkg.sv ====
`default_nettype none

`include "tlb_defines.svh"

package tlb_pkg;

    // Values as written to the command register
    typedef enum logic [1:0] {
        TLB_OP_NONE  = 2'd0,
        TLB_OP_PROBE = 2'd1,
        TLB_OP_READ  = 2'd2,
        TLB_OP_WRITE = 2'd3
    } tlb_op_t;

    // One page half of an entry
    typedef struct packed {
        logic [`PFN_W-1:0] pfn;
        logic [2:0]        c;
        logic              d;
        logic              v;
    } tlb_lo_t;

    typedef struct packed {
        logic [`VPN2_W-1:0] vpn2;
        logic [`ASID_W-1:0] asid;
        logic [`MASK_W-1:0] mask;
        logic               g;
        tlb_lo_t            lo0;
        tlb_lo_t            lo1;
    } tlb_entry_t;

    typedef struct packed {
        logic                  hit;
        logic [`TLB_IDX_W-1:0] index;
        tlb_lo_t               lo;
    } lookup_res_t;

    typedef struct packed {
        logic        mapped;
        logic        write;
        logic [31:0] vaddr;
    } xlat_req_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        refill;
        logic        invalid;
        logic        modified;
    } xlat_resp_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_resp_t;

endpackage

`default_nettype wire

// ==== tlb_defines.svh ====
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// TLB geometry
`define TLB_ENTRIES 32
`define TLB_IDX_W   5

// Entry field widths
`define VPN2_W      19
`define ASID_W      8
`define PFN_W       20
`define MASK_W      12

// APB byte offsets of the management registers
`define REG_INDEX    8'h00
`define REG_ENTRYHI  8'h04
`define REG_ENTRYLO0 8'h08
`define REG_ENTRYLO1 8'h0C
`define REG_PAGEMASK 8'h10
`define REG_CMD      8'h14

`endif
